/* include/gci_defs.svh */
// Hub widths, node count and address map
// Shared by the package and every hub block
`ifndef GCI_DEFS_SVH
`define GCI_DEFS_SVH

// Bus widths
`define GCI_ADDR_W 32
`define GCI_DATA_W 32
`define GCI_PRIO_W 8

// Node count and target id width
`define GCI_NODE_NUM 4
`define GCI_ID_W 3

// Status memory region at the bottom of the map
`define GCI_SMEM_SIZE 32'h400
`define GCI_SMEM_AW 10

`endif

/* design/gci_pkg.sv */
// Shared types of the interconnect hub
// Node info, bus requests and decode results
`include "gci_defs.svh"

package gci_pkg;

	// 0 is the status memory, 1 to 4 the nodes
	typedef logic [`GCI_ID_W-1:0] node_id_t;

	// Driven by a node while it announces itself
	typedef struct packed {
		logic                   present;
		logic                   info_valid;
		logic [`GCI_PRIO_W-1:0] prio;
		logic [`GCI_ADDR_W-1:0] memsize;
	} node_announce_t;

	// Registered copy held by the hub
	typedef struct packed {
		logic                   valid;
		logic                   present;
		logic [`GCI_PRIO_W-1:0] prio;
		logic [`GCI_ADDR_W-1:0] memsize;
	} node_info_t;

	// Entry 0 belongs to node 1
	typedef node_info_t [`GCI_NODE_NUM-1:0] info_table_t;

	typedef struct packed {
		logic                   rw;     // 1 = write
		logic [`GCI_ADDR_W-1:0] addr;
		logic [`GCI_DATA_W-1:0] data;
	} bus_req_t;

	// Target and the address inside its window
	typedef struct packed {
		node_id_t               id;
		logic [`GCI_ADDR_W-1:0] addr;
	} decode_t;

endpackage

/* design/gci_node_registry.sv */
// Node info registry
// Latches node announcements and flags when every present node has announced
`timescale 1ns/1ps
`include "gci_defs.svh"

module gci_node_registry (
	input  logic                                          iCLOCK,
	input  logic                                          inRESET,
	input  gci_pkg::node_announce_t [`GCI_NODE_NUM-1:0]  node_announce,
	output gci_pkg::info_table_t                          info_table,
	output logic                                          init_done
);

	logic [`GCI_NODE_NUM-1:0] node_ok;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `GCI_NODE_NUM; i++) begin
				info_table[i].valid   <= 1'b0;
				info_table[i].present <= 1'b1;  // Held back until the port is seen
				info_table[i].prio    <= '0;
				info_table[i].memsize <= '0;    // Empty window while unknown
			end
		end else begin
			for (int i = 0; i < `GCI_NODE_NUM; i++) begin
				info_table[i].present <= node_announce[i].present;
				if (node_announce[i].info_valid) begin
					info_table[i].prio <= node_announce[i].prio;  // Priority may change later
					// Window size fixed by the first announcement
					if (!info_table[i].valid) begin
						info_table[i].valid   <= 1'b1;
						info_table[i].memsize <= node_announce[i].memsize;
					end
				end
			end
		end
	end

	genvar g;
	for (g = 0; g < `GCI_NODE_NUM; g++) begin : g_node
		assign node_ok[g] = !info_table[g].present || info_table[g].valid;

		// Address map must not move under the decoder once a node is known
		memsize_locked: assert property (
			@(posedge iCLOCK) disable iff (!inRESET)
			info_table[g].valid |=> $stable(info_table[g].memsize)
		);
	end

	assign init_done = &node_ok;

endmodule

/* design/gci_addr_decoder.sv */
// Address decoder
// Maps a CPU address onto the status memory or a node window
`timescale 1ns/1ps
`include "gci_defs.svh"

module gci_addr_decoder (
	input  logic [`GCI_ADDR_W-1:0] addr,
	input  gci_pkg::info_table_t   info_table,
	output gci_pkg::decode_t       decode
);

	// One extra bit so the running sum cannot wrap
	logic [`GCI_ADDR_W:0] base;
	logic [`GCI_ADDR_W:0] limit;
	logic                 hit;

	always_comb begin
		base        = {1'b0, `GCI_SMEM_SIZE};
		limit       = base;
		hit         = 1'b0;
		decode.id   = '0;   // Miss falls back to status memory offset 0
		decode.addr = '0;

		if ({1'b0, addr} < base) begin
			decode.addr = addr;
			hit         = 1'b1;
		end

		// Windows follow one another in node order
		for (int i = 0; i < `GCI_NODE_NUM; i++) begin
			limit = base + {1'b0, info_table[i].memsize};
			if (!hit && ({1'b0, addr} < limit)) begin
				decode.id   = gci_pkg::node_id_t'(i + 1);
				decode.addr = addr - base[`GCI_ADDR_W-1:0];
				hit         = 1'b1;
			end
			base = limit;  // Absent node adds nothing
		end
	end

endmodule

/* design/gci_hub_smem.sv */
// Hub status memory
// Read-only view of node presence, info flags, window sizes and priorities
`timescale 1ns/1ps
`include "gci_defs.svh"

module gci_hub_smem (
	input  logic                    iCLOCK,
	input  logic                    inRESET,
	input  logic                    smem_req_valid,
	input  logic [`GCI_SMEM_AW-1:0] offset,
	input  gci_pkg::info_table_t    info_table,
	output logic                    smem_resp_valid,
	output logic [`GCI_DATA_W-1:0]  smem_resp_data
);

	localparam int VALID_LSB = 8;  // Info-valid bits in word 0

	logic [`GCI_SMEM_AW-3:0] word_idx;
	logic [`GCI_DATA_W-1:0]  rdata;

	assign word_idx = offset[`GCI_SMEM_AW-1:2];  // Byte offset to word

	always_comb begin
		rdata = '0;
		if (word_idx == '0) begin
			for (int i = 0; i < `GCI_NODE_NUM; i++) begin
				rdata[i]             = info_table[i].present;
				rdata[VALID_LSB + i] = info_table[i].valid;
			end
		end
		// Two words per node after the flag word
		for (int i = 0; i < `GCI_NODE_NUM; i++) begin
			if (word_idx == (`GCI_SMEM_AW-2)'(2 * i + 1)) begin
				rdata = info_table[i].memsize;
			end else if (word_idx == (`GCI_SMEM_AW-2)'(2 * i + 2)) begin
				rdata = `GCI_DATA_W'(info_table[i].prio);
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			smem_resp_valid <= 1'b0;
		end else begin
			smem_resp_valid <= smem_req_valid;  // Writes answered the same way
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (smem_req_valid) begin
			smem_resp_data <= rdata;
		end
	end

endmodule

/* design/gci_hub_sequencer.sv */
// Hub transaction sequencer
// Takes one CPU request, pulses one target, waits for it and returns read data
`timescale 1ns/1ps
`include "gci_defs.svh"

module gci_hub_sequencer (
	input  logic                                     iCLOCK,
	input  logic                                     inRESET,
	input  logic                                     init_done,
	input  gci_pkg::decode_t                         decode,
	input  gci_pkg::bus_req_t                        cpu_req,
	input  logic                                     cpu_req_valid,
	output logic                                     cpu_req_ready,
	output logic [`GCI_DATA_W-1:0]                   cpu_resp_data,
	output logic                                     cpu_resp_valid,
	input  logic                                     cpu_resp_ready,
	output logic [`GCI_NODE_NUM-1:0]                 node_req_valid,
	output gci_pkg::bus_req_t                        node_req,
	input  logic [`GCI_NODE_NUM-1:0]                 node_resp_valid,
	input  logic [`GCI_NODE_NUM-1:0][`GCI_DATA_W-1:0] node_resp_data,
	output logic                                     smem_req_valid,
	input  logic                                     smem_resp_valid,
	input  logic [`GCI_DATA_W-1:0]                   smem_resp_data
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_RESP
	} state_t;

	state_t                 state;
	gci_pkg::node_id_t      id_q;       // Target of the open transaction
	logic                   accept;
	logic                   sel_valid;
	logic [`GCI_DATA_W-1:0] sel_data;

	assign cpu_req_ready  = (state == S_IDLE) && init_done;
	assign accept         = cpu_req_valid && cpu_req_ready;
	assign cpu_resp_valid = (state == S_RESP);

	// Only the stored target may end the wait
	always_comb begin
		sel_valid = 1'b0;
		sel_data  = smem_resp_data;
		if (id_q == '0) begin
			sel_valid = smem_resp_valid;
		end
		for (int i = 0; i < `GCI_NODE_NUM; i++) begin
			if (id_q == gci_pkg::node_id_t'(i + 1)) begin
				sel_valid = node_resp_valid[i];
				sel_data  = node_resp_data[i];
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state          <= S_IDLE;
			id_q           <= '0;
			node_req_valid <= '0;
			smem_req_valid <= 1'b0;
		end else begin
			node_req_valid <= '0;  // Target requests are one-cycle pulses
			smem_req_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_WAIT;
						id_q  <= decode.id;
						if (decode.id == '0) begin
							smem_req_valid <= 1'b1;
						end
						for (int i = 0; i < `GCI_NODE_NUM; i++) begin
							if (decode.id == gci_pkg::node_id_t'(i + 1)) begin
								node_req_valid[i] <= 1'b1;
							end
						end
					end
				end
				S_WAIT: begin
					if (sel_valid) begin
						state <= node_req.rw ? S_IDLE : S_RESP;  // Write acks dropped here
					end
				end
				S_RESP: begin
					if (cpu_resp_ready) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			node_req.rw   <= cpu_req.rw;
			node_req.addr <= decode.addr;  // Local address inside the window
			node_req.data <= cpu_req.data;
		end
		if ((state == S_WAIT) && sel_valid && !node_req.rw) begin
			cpu_resp_data <= sel_data;
		end
	end

	// Decoder and pulse logic together must never address two targets
	one_target: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		$onehot0({node_req_valid, smem_req_valid})
	);

	resp_held: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		cpu_resp_valid && !cpu_resp_ready |=> cpu_resp_valid && $stable(cpu_resp_data)
	);

endmodule

/* design/gci_hub_top.sv */
// Interconnect hub top level
// Registry, address decoder, status memory and sequencer between CPU and nodes
`timescale 1ns/1ps
`include "gci_defs.svh"

module gci_hub_top (
	input  logic                                     iCLOCK,
	input  logic                                     inRESET,
	// CPU side
	input  gci_pkg::bus_req_t                        cpu_req,
	input  logic                                     cpu_req_valid,
	output logic                                     cpu_req_ready,
	output logic [`GCI_DATA_W-1:0]                   cpu_resp_data,
	output logic                                     cpu_resp_valid,
	input  logic                                     cpu_resp_ready,
	// Node side
	input  gci_pkg::node_announce_t [`GCI_NODE_NUM-1:0] node_announce,
	output logic [`GCI_NODE_NUM-1:0]                 node_req_valid,
	output gci_pkg::bus_req_t                        node_req,
	input  logic [`GCI_NODE_NUM-1:0]                 node_resp_valid,
	input  logic [`GCI_NODE_NUM-1:0][`GCI_DATA_W-1:0] node_resp_data
);

	gci_pkg::info_table_t   info_table;
	logic                   init_done;
	gci_pkg::decode_t       decode;
	logic                   smem_req_valid;
	logic                   smem_resp_valid;
	logic [`GCI_DATA_W-1:0] smem_resp_data;

	gci_node_registry u_registry (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.node_announce (node_announce),
		.info_table    (info_table),
		.init_done     (init_done)
	);

	gci_addr_decoder u_decoder (
		.addr       (cpu_req.addr),
		.info_table (info_table),
		.decode     (decode)
	);

	// Status memory sees the low bits of the shared target request
	gci_hub_smem u_smem (
		.iCLOCK          (iCLOCK),
		.inRESET         (inRESET),
		.smem_req_valid  (smem_req_valid),
		.offset          (node_req.addr[`GCI_SMEM_AW-1:0]),
		.info_table      (info_table),
		.smem_resp_valid (smem_resp_valid),
		.smem_resp_data  (smem_resp_data)
	);

	gci_hub_sequencer u_sequencer (
		.iCLOCK          (iCLOCK),
		.inRESET         (inRESET),
		.init_done       (init_done),
		.decode          (decode),
		.cpu_req         (cpu_req),
		.cpu_req_valid   (cpu_req_valid),
		.cpu_req_ready   (cpu_req_ready),
		.cpu_resp_data   (cpu_resp_data),
		.cpu_resp_valid  (cpu_resp_valid),
		.cpu_resp_ready  (cpu_resp_ready),
		.node_req_valid  (node_req_valid),
		.node_req        (node_req),
		.node_resp_valid (node_resp_valid),
		.node_resp_data  (node_resp_data),
		.smem_req_valid  (smem_req_valid),
		.smem_resp_valid (smem_resp_valid),
		.smem_resp_data  (smem_resp_data)
	);

endmodule

/* verification/tb_gci_hub.sv */
// Directed testbench for the interconnect hub
// Node models answer target requests, compare tasks check CPU and node traffic
`timescale 1ns/1ps
`include "gci_defs.svh"

module tb_gci_hub;

	localparam int CLK_PERIOD      = 4;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int POOL            = 64;

	// Node model setup with entry 0 for node 1
	localparam logic [3:0]  NODE_PRESENT = 4'b1011;
	localparam logic [31:0] NODE_SIZE [4] = '{32'h100, 32'h200, 32'h0, 32'h80};
	localparam logic [7:0]  NODE_PRIO [4] = '{8'd5, 8'd7, 8'd0, 8'd9};

	logic                                          iCLOCK;
	logic                                          inRESET;
	gci_pkg::bus_req_t                             cpu_req;
	logic                                          cpu_req_valid;
	logic                                          cpu_req_ready;
	logic [`GCI_DATA_W-1:0]                        cpu_resp_data;
	logic                                          cpu_resp_valid;
	logic                                          cpu_resp_ready;
	gci_pkg::node_announce_t [`GCI_NODE_NUM-1:0]   node_announce;
	logic [`GCI_NODE_NUM-1:0]                      node_req_valid;
	gci_pkg::bus_req_t                             node_req;
	logic [`GCI_NODE_NUM-1:0]                      node_resp_valid = '0;
	logic [`GCI_NODE_NUM-1:0][`GCI_DATA_W-1:0]     node_resp_data = '0;

	gci_pkg::bus_req_t last_req [4];  // Last request seen by each node
	int                req_count [4];
	int unsigned       delay_pool [POOL];
	int                pool_idx = 0;
	int                errors = 0;
	int                tests_run = 0;
	int                tests_failed = 0;

	gci_hub_top dut (
		.iCLOCK          (iCLOCK),
		.inRESET         (inRESET),
		.cpu_req         (cpu_req),
		.cpu_req_valid   (cpu_req_valid),
		.cpu_req_ready   (cpu_req_ready),
		.cpu_resp_data   (cpu_resp_data),
		.cpu_resp_valid  (cpu_resp_valid),
		.cpu_resp_ready  (cpu_resp_ready),
		.node_announce   (node_announce),
		.node_req_valid  (node_req_valid),
		.node_req        (node_req),
		.node_resp_valid (node_resp_valid),
		.node_resp_data  (node_resp_data)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	// Node number on top of the local address
	function automatic logic [31:0] node_data(input int node, input logic [31:0] local_addr);
		return {4'(node), local_addr[27:0]};
	endfunction

	task automatic report_error(input string msg);
		$display("Error: %s", msg);
		errors++;
	endtask

	task automatic check_data(input string name, input logic [`GCI_DATA_W-1:0] exp,
			input logic [`GCI_DATA_W-1:0] act);
		if (act !== exp) begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_req(input string name, input gci_pkg::bus_req_t exp,
			input gci_pkg::bus_req_t act);
		if (act !== exp) begin
			$display("Mismatch %s: expected rw=%0b addr=%h data=%h, actual rw=%0b addr=%h data=%h",
				name, exp.rw, exp.addr, exp.data, act.rw, act.addr, act.data);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start) begin
			$display("test %-14s ok", name);
		end else begin
			tests_failed++;
			$display("test %-14s failed", name);
		end
	endtask

	// One model serves all nodes since the hub keeps one transaction open
	always begin : node_model
		int          n;
		int unsigned d;
		@(negedge iCLOCK);
		n = -1;
		for (int i = 0; i < `GCI_NODE_NUM; i++) begin
			if (node_req_valid[i]) n = i;
		end
		if (n >= 0) begin
			if (!NODE_PRESENT[n]) begin
				report_error($sformatf("request sent to absent node %0d", n + 1));
			end
			last_req[n] = node_req;
			req_count[n]++;
			d = delay_pool[pool_idx];
			pool_idx = (pool_idx + 1) % POOL;
			repeat (d) @(posedge iCLOCK);
			#1;
			node_resp_valid[n] = 1'b1;
			node_resp_data[n]  = last_req[n].rw ? '0 : node_data(n + 1, last_req[n].addr);
			@(posedge iCLOCK);
			#1;
			node_resp_valid[n] = 1'b0;
		end
	end

	// Entered and left 1 ns after a rising edge
	task automatic send_req(input logic rw, input logic [31:0] addr, input logic [31:0] data);
		cpu_req       = '{rw: rw, addr: addr, data: data};
		cpu_req_valid = 1'b1;
		do @(negedge iCLOCK); while (!cpu_req_ready);
		@(posedge iCLOCK);
		#1;
		cpu_req_valid = 1'b0;
	endtask

	task automatic cpu_read(input string name, input logic [31:0] addr, input int hold,
			output logic [31:0] data, output int lat);
		cpu_resp_ready = (hold == 0);
		send_req(1'b0, addr, 32'h0);
		lat = 0;
		forever begin
			@(negedge iCLOCK);
			if (cpu_resp_valid) break;
			lat++;
		end
		data = cpu_resp_data;
		// Response must hold up to the edge that takes it
		for (int c = 0; c < hold; c++) begin
			@(posedge iCLOCK);
			#1;
			if (c == hold - 1) cpu_resp_ready = 1'b1;
			@(negedge iCLOCK);
			if (!cpu_resp_valid) begin
				report_error($sformatf("%s response dropped while held back", name));
			end
			check_data(name, data, cpu_resp_data);
			if (cpu_req_ready) report_error("cpu_req_ready high while a response is pending");
		end
		@(posedge iCLOCK);  // Response taken here
		#1;
	endtask

	task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
		send_req(1'b1, addr, data);
		do begin
			@(negedge iCLOCK);
			if (cpu_resp_valid) report_error("CPU response appeared for a write");
		end while (!cpu_req_ready);
		@(posedge iCLOCK);
		#1;
	endtask

	task automatic read_node(input string name, input logic [31:0] addr, input int node,
			input logic [31:0] local_addr, input int hold);
		logic [31:0] data;
		int          lat;
		int          count0;
		count0 = req_count[node - 1];
		cpu_read(name, addr, hold, data, lat);
		check_data(name, node_data(node, local_addr), data);
		check_req(name, '{rw: 1'b0, addr: local_addr, data: 32'h0}, last_req[node - 1]);
		if (req_count[node - 1] != count0 + 1) begin
			report_error($sformatf("%s missed node %0d", name, node));
		end
	endtask

	task automatic read_smem(input string name, input logic [31:0] addr, input int hold,
			input logic [31:0] exp);
		logic [31:0] data;
		int          lat;
		cpu_read(name, addr, hold, data, lat);
		check_data(name, exp, data);
		if (hold == 0 && lat != 2)
			report_error($sformatf("%s took %0d cycles instead of 2", name, lat));
	endtask

	task automatic test_init_gating();
		int errs;
		int waited;
		errs = errors;
		repeat (12) begin
			@(negedge iCLOCK);
			if (cpu_req_ready) report_error("cpu_req_ready high before node 4 announced");
		end
		@(posedge iCLOCK);
		#1;
		node_announce[3].info_valid = 1'b1;
		waited = 0;
		do begin
			@(negedge iCLOCK);
			waited++;
		end while (!cpu_req_ready && waited < 4);
		if (!cpu_req_ready) report_error("cpu_req_ready stayed low after node 4 announced");
		@(posedge iCLOCK);
		#1;
		finish_test("init_gating", errs);
	endtask

	task automatic test_read_routing();
		int errs;
		errs = errors;
		read_node("read 0x400", 32'h400, 1, 32'h0, 0);
		read_node("read 0x4ff", 32'h4FF, 1, 32'hFF, 0);
		read_node("read 0x500", 32'h500, 2, 32'h0, 0);
		read_node("read 0x6ff", 32'h6FF, 2, 32'h1FF, 0);
		read_node("read 0x700", 32'h700, 4, 32'h0, 0);
		read_node("read 0x77f", 32'h77F, 4, 32'h7F, 0);
		finish_test("read_routing", errs);
	endtask

	task automatic test_writes();
		int          errs;
		logic [31:0] wdata;
		errs = errors;
		wdata = $urandom;
		cpu_write(32'h410, wdata);
		check_req("write node 1", '{rw: 1'b1, addr: 32'h10, data: wdata}, last_req[0]);
		wdata = $urandom;
		cpu_write(32'h5A0, wdata);
		check_req("write node 2", '{rw: 1'b1, addr: 32'hA0, data: wdata}, last_req[1]);
		wdata = $urandom;
		cpu_write(32'h744, wdata);
		check_req("write node 4", '{rw: 1'b1, addr: 32'h44, data: wdata}, last_req[3]);
		finish_test("writes", errs);
	endtask

	task automatic test_status_mem();
		int          errs;
		logic [31:0] exp;
		errs = errors;
		for (int w = 0; w <= 8; w++) begin
			// Valid follows presence
			if (w == 0) exp = {20'h0, NODE_PRESENT, 4'h0, NODE_PRESENT};
			else if (w % 2 == 1) exp = NODE_SIZE[(w - 1) / 2];
			else exp = 32'(NODE_PRIO[(w - 2) / 2]);
			read_smem($sformatf("smem word %0d", w), 32'(4 * w), 0, exp);
		end
		// Second announcement moves only the priority
		node_announce[1].prio    = 8'd3;
		node_announce[1].memsize = 32'h999;
		repeat (2) @(posedge iCLOCK);
		#1;
		read_smem("smem word 4 after update", 32'h10, 0, 32'h3);
		read_smem("smem word 3 after update", 32'hC, 0, 32'h200);
		finish_test("status_mem", errs);
	endtask

	task automatic test_out_of_range();
		int errs;
		errs = errors;
		read_smem("read 0x780", 32'h780, 0, {20'h0, NODE_PRESENT, 4'h0, NODE_PRESENT});
		read_smem("read 0x1000", 32'h1000, 0, {20'h0, NODE_PRESENT, 4'h0, NODE_PRESENT});
		read_smem("read 0xfffffff0", 32'hFFFF_FFF0, 0, {20'h0, NODE_PRESENT, 4'h0, NODE_PRESENT});
		finish_test("out_of_range", errs);
	endtask

	task automatic test_backpressure();
		int errs;
		errs = errors;
		read_node("held 0x480", 32'h480, 1, 32'h80, 1 + int'($urandom % 8));
		read_node("held 0x6f0", 32'h6F0, 2, 32'h1F0, 1 + int'($urandom % 8));
		read_smem("held smem word 1", 32'h4, 1 + int'($urandom % 8), 32'h100);
		read_node("held 0x77c", 32'h77C, 4, 32'h7C, 1 + int'($urandom % 8));
		finish_test("backpressure", errs);
	endtask

	initial begin : watchdog
		#((NUM_TESTS * CYCLES_PER_TEST + 8) * CLK_PERIOD);
		$display("Error: watchdog expired before the tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h2ec8cfff));
		for (int i = 0; i < POOL; i++) delay_pool[i] = 32'd1 + ($urandom % 32'd5);
		inRESET        = 1'b0;
		cpu_req        = '0;
		cpu_req_valid  = 1'b0;
		cpu_resp_ready = 1'b1;
		for (int i = 0; i < `GCI_NODE_NUM; i++) begin
			node_announce[i] = '{present: NODE_PRESENT[i], info_valid: NODE_PRESENT[i] && i != 3,
				prio: NODE_PRIO[i], memsize: NODE_SIZE[i]};  // Node 4 announces later
			req_count[i] = 0;
			last_req[i]  = '0;
		end
		repeat (4) @(posedge iCLOCK);
		@(negedge iCLOCK);
		if (cpu_req_ready || cpu_resp_valid || node_req_valid != '0 || dut.smem_req_valid)
			report_error("hub outputs not low during reset");
		repeat (4) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		test_init_gating();
		test_read_routing();
		test_writes();
		test_status_mem();
		test_out_of_range();
		test_backpressure();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+include
design/gci_pkg.sv
design/gci_node_registry.sv
design/gci_addr_decoder.sv
design/gci_hub_smem.sv
design/gci_hub_sequencer.sv
design/gci_hub_top.sv
verification/tb_gci_hub.sv

/* Makefile */
# Verilator flow for the interconnect hub testbench

TOP = tb_gci_hub
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		--Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
